//--- design/soc_pkg.sv
// Memory system shared definitions
package soc_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // Memory map
    localparam logic [ADDR_W-1:0] CODE_BASE = 32'h0000_0000;
    localparam logic [ADDR_W-1:0] CODE_SIZE = 32'h0000_1000;
    localparam logic [ADDR_W-1:0] DATA_BASE = 32'h1000_0000;
    localparam logic [ADDR_W-1:0] DATA_SIZE = 32'h0000_1000;

    // Everything from here up is register space
    localparam logic [ADDR_W-1:0] MMIO_BASE = 32'h8000_0000;

    // AXI response codes
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_t;

    // Register offsets inside the MMIO block
    typedef enum logic [3:0] {
        REG_SCRATCH = 4'h0,
        REG_WCOUNT  = 4'h4,
        REG_LED     = 4'h8
    } mmio_reg_t;

    localparam int LED_W = 8;

endpackage : soc_pkg

//--- design/axi_lite_if.sv
// AXI-lite bus interface
`timescale 1ns/1ps

interface axi_lite_if;

    // Write address
    logic [soc_pkg::ADDR_W-1:0]   awaddr;
    logic [2:0]                   awprot;
    logic                         awvalid;
    logic                         awready;

    // Write data
    logic [soc_pkg::DATA_W-1:0]   wdata;
    logic [soc_pkg::DATA_W/8-1:0] wstrb;
    logic                         wvalid;
    logic                         wready;

    // Write response
    soc_pkg::resp_t               bresp;
    logic                         bvalid;
    logic                         bready;

    // Read address
    logic [soc_pkg::ADDR_W-1:0]   araddr;
    logic [2:0]                   arprot;
    logic                         arvalid;
    logic                         arready;

    // Read data
    logic [soc_pkg::DATA_W-1:0]   rdata;
    soc_pkg::resp_t               rresp;
    logic                         rvalid;
    logic                         rready;

    modport master (
        output awaddr, awprot, awvalid, wdata, wstrb, wvalid, bready,
        output araddr, arprot, arvalid, rready,
        input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );

    modport slave (
        input  awaddr, awprot, awvalid, wdata, wstrb, wvalid, bready,
        input  araddr, arprot, arvalid, rready,
        output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );

endinterface : axi_lite_if

//--- design/mem_router.sv
// Address decode and channel routing
`timescale 1ns/1ps

module mem_router (
    axi_lite_if.slave  cache,
    axi_lite_if.master code,
    axi_lite_if.master data,
    axi_lite_if.master mmio,
    output logic       fault
);

    typedef enum logic [1:0] { NONE, CODE, DATA, MMIO } target_t;

    target_t wr_tgt;
    target_t rd_tgt;

    function automatic target_t decode(input logic [soc_pkg::ADDR_W-1:0] addr);
        // Offset compare wraps for addresses below the base
        if (addr - soc_pkg::CODE_BASE < soc_pkg::CODE_SIZE) begin
            return CODE;
        end
        if (addr - soc_pkg::DATA_BASE < soc_pkg::DATA_SIZE) begin
            return DATA;
        end
        if (addr >= soc_pkg::MMIO_BASE) begin
            return MMIO;
        end
        return NONE;
    endfunction

    assign wr_tgt = decode(cache.awaddr);
    assign rd_tgt = decode(cache.araddr);

    // Payload goes to every target
    assign code.awaddr = cache.awaddr;
    assign code.awprot = cache.awprot;
    assign code.wdata  = cache.wdata;
    assign code.wstrb  = cache.wstrb;
    assign data.awaddr = cache.awaddr;
    assign data.awprot = cache.awprot;
    assign data.wdata  = cache.wdata;
    assign data.wstrb  = cache.wstrb;
    assign mmio.awaddr = cache.awaddr;
    assign mmio.awprot = cache.awprot;
    assign mmio.wdata  = cache.wdata;
    assign mmio.wstrb  = cache.wstrb;

    assign code.araddr = cache.araddr;
    assign code.arprot = cache.arprot;
    assign data.araddr = cache.araddr;
    assign data.arprot = cache.arprot;
    assign mmio.araddr = cache.araddr;
    assign mmio.arprot = cache.arprot;

    // Code memory is fetched through its own port, never read here
    assign code.arvalid = 1'b0;
    assign code.rready  = 1'b0;

    // Write channels
    always_comb begin
        code.awvalid  = 1'b0;
        code.wvalid   = 1'b0;
        code.bready   = 1'b0;
        data.awvalid  = 1'b0;
        data.wvalid   = 1'b0;
        data.bready   = 1'b0;
        mmio.awvalid  = 1'b0;
        mmio.wvalid   = 1'b0;
        mmio.bready   = 1'b0;
        // Unmapped writes complete at once
        cache.awready = 1'b1;
        cache.wready  = 1'b1;
        cache.bvalid  = 1'b1;
        cache.bresp   = soc_pkg::DECERR;
        case (wr_tgt)
            CODE: begin
                code.awvalid  = cache.awvalid;
                code.wvalid   = cache.wvalid;
                code.bready   = cache.bready;
                cache.awready = code.awready;
                cache.wready  = code.wready;
                cache.bvalid  = code.bvalid;
                cache.bresp   = code.bresp;
            end
            DATA: begin
                data.awvalid  = cache.awvalid;
                data.wvalid   = cache.wvalid;
                data.bready   = cache.bready;
                cache.awready = data.awready;
                cache.wready  = data.wready;
                cache.bvalid  = data.bvalid;
                cache.bresp   = data.bresp;
            end
            MMIO: begin
                mmio.awvalid  = cache.awvalid;
                mmio.wvalid   = cache.wvalid;
                mmio.bready   = cache.bready;
                cache.awready = mmio.awready;
                cache.wready  = mmio.wready;
                cache.bvalid  = mmio.bvalid;
                cache.bresp   = mmio.bresp;
            end
            default: ;
        endcase
    end

    // Read channels, code and unmapped both end in DECERR
    always_comb begin
        data.arvalid  = 1'b0;
        data.rready   = 1'b0;
        mmio.arvalid  = 1'b0;
        mmio.rready   = 1'b0;
        cache.arready = 1'b1;
        cache.rvalid  = 1'b1;
        cache.rdata   = '0;
        cache.rresp   = soc_pkg::DECERR;
        case (rd_tgt)
            DATA: begin
                data.arvalid  = cache.arvalid;
                data.rready   = cache.rready;
                cache.arready = data.arready;
                cache.rvalid  = data.rvalid;
                cache.rdata   = data.rdata;
                cache.rresp   = data.rresp;
            end
            MMIO: begin
                mmio.arvalid  = cache.arvalid;
                mmio.rready   = cache.rready;
                cache.arready = mmio.arready;
                cache.rvalid  = mmio.rvalid;
                cache.rdata   = mmio.rdata;
                cache.rresp   = mmio.rresp;
            end
            default: ;
        endcase
    end

    assign fault = cache.arvalid & (rd_tgt == NONE);

endmodule : mem_router

//--- design/code_mem.sv
// Code memory with fetch port
`timescale 1ns/1ps

module code_mem #(
    parameter int DEPTH = 1024
) (
    input  logic                       aclk,
    input  logic                       arst_n,
    axi_lite_if.slave                  bus,
    input  logic [soc_pkg::ADDR_W-1:0] fetch_addr,
    output logic [soc_pkg::DATA_W-1:0] fetch_data
);

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [soc_pkg::DATA_W-1:0] mem [DEPTH];
    logic [IDX_W-1:0]           wr_idx;
    logic [IDX_W-1:0]           fetch_idx;
    logic                       wr_go;

    assign wr_idx    = bus.awaddr[IDX_W+1:2];
    assign fetch_idx = fetch_addr[IDX_W+1:2];

    // Accept AW and W together while no response is waiting
    assign wr_go       = bus.awvalid & bus.wvalid & ~bus.bvalid;
    assign bus.awready = wr_go;
    assign bus.wready  = wr_go;
    assign bus.bresp   = soc_pkg::OKAY;

    // Read channels unused
    assign bus.arready = 1'b1;
    assign bus.rvalid  = 1'b0;
    assign bus.rresp   = soc_pkg::OKAY;
    assign bus.rdata   = '0;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            bus.bvalid <= 1'b0;
        end else if (wr_go) begin
            bus.bvalid <= 1'b1;
        end else if (bus.bready) begin
            bus.bvalid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_go) begin
            for (int i = 0; i < soc_pkg::DATA_W / 8; i++) begin
                if (bus.wstrb[i]) begin
                    mem[wr_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
                end
            end
        end
        fetch_data <= mem[fetch_idx];
    end

endmodule : code_mem

//--- design/data_mem.sv
// Data memory
`timescale 1ns/1ps

module data_mem #(
    parameter int DEPTH = 1024
) (
    input  logic      aclk,
    input  logic      arst_n,
    axi_lite_if.slave bus
);

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [soc_pkg::DATA_W-1:0] mem [DEPTH];
    logic [IDX_W-1:0]           wr_idx;
    logic [IDX_W-1:0]           rd_idx;
    logic                       wr_go;
    logic                       rd_go;

    // Word index, upper bits dropped so addresses wrap
    assign wr_idx = bus.awaddr[IDX_W+1:2];
    assign rd_idx = bus.araddr[IDX_W+1:2];

    assign wr_go       = bus.awvalid & bus.wvalid & ~bus.bvalid;
    assign bus.awready = wr_go;
    assign bus.wready  = wr_go;
    assign bus.bresp   = soc_pkg::OKAY;

    assign bus.arready = ~bus.rvalid;
    assign rd_go       = bus.arvalid & ~bus.rvalid;
    assign bus.rresp   = soc_pkg::OKAY;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            bus.bvalid <= 1'b0;
            bus.rvalid <= 1'b0;
        end else begin
            if (wr_go) begin
                bus.bvalid <= 1'b1;
            end else if (bus.bready) begin
                bus.bvalid <= 1'b0;
            end
            if (rd_go) begin
                bus.rvalid <= 1'b1;
            end else if (bus.rready) begin
                bus.rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_go) begin
            for (int i = 0; i < soc_pkg::DATA_W / 8; i++) begin
                if (bus.wstrb[i]) begin
                    mem[wr_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
                end
            end
        end
        // Read data held until the next accepted read
        if (rd_go) begin
            bus.rdata <= mem[rd_idx];
        end
    end

endmodule : data_mem

//--- design/mmio_regs.sv
// Memory-mapped register block
`timescale 1ns/1ps

module mmio_regs (
    input  logic                      aclk,
    input  logic                      arst_n,
    axi_lite_if.slave                 bus,
    output logic [soc_pkg::LED_W-1:0] led
);

    logic [soc_pkg::ADDR_W-1:0] woff;
    logic [soc_pkg::ADDR_W-1:0] roff;
    logic [soc_pkg::DATA_W-1:0] scratch;
    logic [soc_pkg::DATA_W-1:0] wcount;
    logic                       wr_go;
    logic                       rd_go;
    logic                       wr_scratch;
    logic                       wr_led;
    logic                       rd_hi_zero;

    assign woff = bus.awaddr - soc_pkg::MMIO_BASE;
    assign roff = bus.araddr - soc_pkg::MMIO_BASE;

    assign wr_scratch = woff[soc_pkg::ADDR_W-1:4] == '0 && woff[3:0] == soc_pkg::REG_SCRATCH;
    assign wr_led     = woff[soc_pkg::ADDR_W-1:4] == '0 && woff[3:0] == soc_pkg::REG_LED;
    assign rd_hi_zero = roff[soc_pkg::ADDR_W-1:4] == '0;

    assign wr_go       = bus.awvalid & bus.wvalid & ~bus.bvalid;
    assign bus.awready = wr_go;
    assign bus.wready  = wr_go;
    assign bus.arready = ~bus.rvalid;
    assign rd_go       = bus.arvalid & ~bus.rvalid;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            bus.bvalid <= 1'b0;
            bus.bresp  <= soc_pkg::OKAY;
            scratch    <= '0;
            wcount     <= '0;
            led        <= '0;
        end else if (wr_go) begin
            bus.bvalid <= 1'b1;
            bus.bresp  <= (wr_scratch || wr_led) ? soc_pkg::OKAY : soc_pkg::SLVERR;
            for (int i = 0; i < soc_pkg::DATA_W / 8; i++) begin
                if (wr_scratch && bus.wstrb[i]) begin
                    scratch[8*i +: 8] <= bus.wdata[8*i +: 8];
                end
            end
            if (wr_led && bus.wstrb[0]) begin
                led <= bus.wdata[soc_pkg::LED_W-1:0];
            end
            // Only good writes are counted
            if (wr_scratch || wr_led) begin
                wcount <= wcount + 32'd1;
            end
        end else if (bus.bready) begin
            bus.bvalid <= 1'b0;
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            bus.rvalid <= 1'b0;
        end else if (rd_go) begin
            bus.rvalid <= 1'b1;
        end else if (bus.rready) begin
            bus.rvalid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_go) begin
            bus.rresp <= soc_pkg::OKAY;
            if (rd_hi_zero && roff[3:0] == soc_pkg::REG_SCRATCH) begin
                bus.rdata <= scratch;
            end else if (rd_hi_zero && roff[3:0] == soc_pkg::REG_WCOUNT) begin
                bus.rdata <= wcount;
            end else if (rd_hi_zero && roff[3:0] == soc_pkg::REG_LED) begin
                bus.rdata <= {{(soc_pkg::DATA_W - soc_pkg::LED_W){1'b0}}, led};
            end else begin
                bus.rdata <= '0;
                bus.rresp <= soc_pkg::SLVERR;
            end
        end
    end

endmodule : mmio_regs

//--- design/mem_system.sv
// Memory system top level
`timescale 1ns/1ps

module mem_system #(
    parameter int CODE_DEPTH = int'(soc_pkg::CODE_SIZE / 4),
    parameter int DATA_DEPTH = int'(soc_pkg::DATA_SIZE / 4)
) (
    input  logic                         aclk,
    input  logic                         arst_n,
    input  logic [soc_pkg::ADDR_W-1:0]   awaddr,
    input  logic [2:0]                   awprot,
    input  logic                         awvalid,
    output logic                         awready,
    input  logic [soc_pkg::DATA_W-1:0]   wdata,
    input  logic [soc_pkg::DATA_W/8-1:0] wstrb,
    input  logic                         wvalid,
    output logic                         wready,
    output soc_pkg::resp_t               bresp,
    output logic                         bvalid,
    input  logic                         bready,
    input  logic [soc_pkg::ADDR_W-1:0]   araddr,
    input  logic [2:0]                   arprot,
    input  logic                         arvalid,
    output logic                         arready,
    output logic [soc_pkg::DATA_W-1:0]   rdata,
    output soc_pkg::resp_t               rresp,
    output logic                         rvalid,
    input  logic                         rready,
    output logic                         fault,
    input  logic [soc_pkg::ADDR_W-1:0]   fetch_addr,
    output logic [soc_pkg::DATA_W-1:0]   fetch_data,
    output logic [soc_pkg::LED_W-1:0]    led
);

    axi_lite_if cache_bus ();
    axi_lite_if code_bus ();
    axi_lite_if data_bus ();
    axi_lite_if mmio_bus ();

    // Master port from the cache
    assign cache_bus.awaddr  = awaddr;
    assign cache_bus.awprot  = awprot;
    assign cache_bus.awvalid = awvalid;
    assign cache_bus.wdata   = wdata;
    assign cache_bus.wstrb   = wstrb;
    assign cache_bus.wvalid  = wvalid;
    assign cache_bus.bready  = bready;
    assign cache_bus.araddr  = araddr;
    assign cache_bus.arprot  = arprot;
    assign cache_bus.arvalid = arvalid;
    assign cache_bus.rready  = rready;

    assign awready = cache_bus.awready;
    assign wready  = cache_bus.wready;
    assign bresp   = cache_bus.bresp;
    assign bvalid  = cache_bus.bvalid;
    assign arready = cache_bus.arready;
    assign rdata   = cache_bus.rdata;
    assign rresp   = cache_bus.rresp;
    assign rvalid  = cache_bus.rvalid;

    mem_router mem_router_i (
        .cache (cache_bus),
        .code  (code_bus),
        .data  (data_bus),
        .mmio  (mmio_bus),
        .fault (fault)
    );

    code_mem #(.DEPTH(CODE_DEPTH)) code_mem_i (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .bus        (code_bus),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data)
    );

    data_mem #(.DEPTH(DATA_DEPTH)) data_mem_i (
        .aclk   (aclk),
        .arst_n (arst_n),
        .bus    (data_bus)
    );

    mmio_regs mmio_regs_i (
        .aclk   (aclk),
        .arst_n (arst_n),
        .bus    (mmio_bus),
        .led    (led)
    );

endmodule : mem_system

//--- dv/mem_system_tb.sv
// Memory system testbench
`timescale 1ns/1ps

module mem_system_tb;

    typedef logic [soc_pkg::ADDR_W-1:0]   addr_t;
    typedef logic [soc_pkg::DATA_W-1:0]   word_t;
    typedef logic [soc_pkg::DATA_W/8-1:0] strb_t;

    typedef enum logic [1:0] { OP_WRITE, OP_READ, OP_FETCH } op_t;

    typedef struct packed {
        op_t            op;
        addr_t          addr;
        word_t          data;
        strb_t          strb;
        logic [3:0]     delay;
        soc_pkg::resp_t exp_resp;
        word_t          exp_data;
        logic           exp_fault;
    } row_t;

    localparam addr_t DB = soc_pkg::DATA_BASE;
    localparam addr_t CB = soc_pkg::CODE_BASE;
    localparam addr_t MB = soc_pkg::MMIO_BASE;

    logic                      aclk;
    logic                      arst_n;
    addr_t                     awaddr;
    logic [2:0]                awprot;
    logic                      awvalid;
    logic                      awready;
    word_t                     wdata;
    strb_t                     wstrb;
    logic                      wvalid;
    logic                      wready;
    soc_pkg::resp_t            bresp;
    logic                      bvalid;
    logic                      bready;
    addr_t                     araddr;
    logic [2:0]                arprot;
    logic                      arvalid;
    logic                      arready;
    word_t                     rdata;
    soc_pkg::resp_t            rresp;
    logic                      rvalid;
    logic                      rready;
    logic                      fault;
    addr_t                     fetch_addr;
    word_t                     fetch_data;
    logic [soc_pkg::LED_W-1:0] led;

    row_t                      rows [$];
    int                        mmio_writes = 0;
    int                        max_delay = 0;
    int                        limit = 0;
    int                        cycles = 0;
    logic [soc_pkg::LED_W-1:0] led_exp = '0;

    mem_system mem_system_i (.*);

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_resp(input string name, input soc_pkg::resp_t exp,
                              input soc_pkg::resp_t act);
        if (act !== exp) begin
            stop_run($sformatf("error: %s expected %h got %h", name, exp, act));
        end
    endtask

    task automatic check_data(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            stop_run($sformatf("error: %s expected %h got %h", name, exp, act));
        end
    endtask

    task automatic check_fault(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("error: %s expected %h got %h", name, exp, act));
        end
    endtask

    task automatic check_led(input string name, input logic [soc_pkg::LED_W-1:0] exp,
                             input logic [soc_pkg::LED_W-1:0] act);
        if (act !== exp) begin
            stop_run($sformatf("error: %s expected %h got %h", name, exp, act));
        end
    endtask

    // Taps 32, 22, 2, 1
    function automatic word_t lfsr_step(input word_t s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Byte lanes with a strobe take the new byte
    function automatic word_t merge(input word_t old_w, input word_t new_w, input strb_t strb);
        word_t res;
        res = old_w;
        for (int i = 0; i < soc_pkg::DATA_W / 8; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return res;
    endfunction

    function automatic addr_t reg_addr(input soc_pkg::mmio_reg_t r);
        return MB + {28'h0, r};
    endfunction

    task automatic add_row(input op_t op, input addr_t addr, input word_t data,
                           input strb_t strb, input int delay, input soc_pkg::resp_t resp,
                           input word_t exp_data, input logic exp_fault);
        row_t r;
        r.op        = op;
        r.addr      = addr;
        r.data      = data;
        r.strb      = strb;
        r.delay     = 4'(delay);
        r.exp_resp  = resp;
        r.exp_data  = exp_data;
        r.exp_fault = exp_fault;
        rows.push_back(r);
        // Running count of good register writes seen by REG_WCOUNT
        if (op == OP_WRITE && resp == soc_pkg::OKAY && addr >= MB) begin
            mmio_writes++;
        end
        if (delay > max_delay) begin
            max_delay = delay;
        end
    endtask

    task automatic build_table();
        word_t state;
        word_t w;
        word_t block [8];
        word_t d0;
        word_t d1;
        state = 32'hf5dc9ad0;
        d0 = merge(32'h1122_3344, 32'haabb_ccdd, 4'b0101);
        d1 = merge(32'hcafe_f00d, 32'h5566_7788, 4'b1000);

        add_row(OP_WRITE, DB, 32'h1122_3344, 4'hf, 0, soc_pkg::OKAY, '0, 1'b0);
        add_row(OP_READ, DB, '0, '0, 0, soc_pkg::OKAY, 32'h1122_3344, 1'b0);
        add_row(OP_WRITE, DB, 32'haabb_ccdd, 4'b0101, 0, soc_pkg::OKAY, '0, 1'b0);
        add_row(OP_READ, DB, '0, '0, 0, soc_pkg::OKAY, d0, 1'b0);
        add_row(OP_WRITE, DB + 32'h4, 32'hcafe_f00d, 4'hf, 3, soc_pkg::OKAY, '0, 1'b0);
        add_row(OP_WRITE, DB + 32'h4, 32'h5566_7788, 4'b1000, 0, soc_pkg::OKAY, '0, 1'b0);
        add_row(OP_READ, DB + 32'h4, '0, '0, 4, soc_pkg::OKAY, d1, 1'b0);

        // Pseudo-random block with one LFSR step per bit
        for (int i = 0; i < 8; i++) begin
            w = '0;
            for (int b = 0; b < soc_pkg::DATA_W; b++) begin
                state = lfsr_step(state);
                w = {w[soc_pkg::DATA_W-2:0], state[0]};
            end
            block[i] = w;
            add_row(OP_WRITE, DB + 32'h100 + 32'(4 * i), w, 4'hf, 0, soc_pkg::OKAY, '0, 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            add_row(OP_READ, DB + 32'h100 + 32'(4 * i), '0, '0, i % 3, soc_pkg::OKAY,
                    block[i], 1'b0);
        end

        add_row(OP_WRITE, CB + 32'h40, 32'h0bad_c0de, 4'hf, 0, soc_pkg::OKAY, '0, 1'b0);
        add_row(OP_FETCH, CB + 32'h40, '0, '0, 0, soc_pkg::OKAY, 32'h0bad_c0de, 1'b0);
        add_row(OP_WRITE, CB + 32'h44, 32'h1234_5678, 4'hf, 1, soc_pkg::OKAY, '0, 1'b0);
        add_row(OP_FETCH, CB + 32'h44, '0, '0, 0, soc_pkg::OKAY, 32'h1234_5678, 1'b0);
        add_row(OP_READ, CB + 32'h40, '0, '0, 0, soc_pkg::DECERR, '0, 1'b0);

        add_row(OP_WRITE, reg_addr(soc_pkg::REG_SCRATCH), 32'hdead_beef, 4'hf, 0,
                soc_pkg::OKAY, '0, 1'b0);
        add_row(OP_WRITE, reg_addr(soc_pkg::REG_SCRATCH), 32'h0000_1234, 4'b0011, 1,
                soc_pkg::OKAY, '0, 1'b0);
        add_row(OP_READ, reg_addr(soc_pkg::REG_SCRATCH), '0, '0, 0, soc_pkg::OKAY,
                merge(32'hdead_beef, 32'h0000_1234, 4'b0011), 1'b0);
        add_row(OP_WRITE, reg_addr(soc_pkg::REG_LED), 32'h0000_01a5, 4'hf, 0,
                soc_pkg::OKAY, '0, 1'b0);
        add_row(OP_READ, reg_addr(soc_pkg::REG_LED), '0, '0, 0, soc_pkg::OKAY,
                32'h0000_00a5, 1'b0);
        add_row(OP_READ, reg_addr(soc_pkg::REG_WCOUNT), '0, '0, 0, soc_pkg::OKAY,
                32'(mmio_writes), 1'b0);
        add_row(OP_WRITE, reg_addr(soc_pkg::REG_WCOUNT), 32'h0000_0055, 4'hf, 0,
                soc_pkg::SLVERR, '0, 1'b0);
        add_row(OP_WRITE, MB + 32'hc, 32'h0000_0066, 4'hf, 2, soc_pkg::SLVERR, '0, 1'b0);
        add_row(OP_READ, reg_addr(soc_pkg::REG_WCOUNT), '0, '0, 1, soc_pkg::OKAY,
                32'(mmio_writes), 1'b0);
        add_row(OP_READ, MB + 32'hc, '0, '0, 0, soc_pkg::SLVERR, '0, 1'b0);

        // Unmapped hole between data and register space
        add_row(OP_WRITE, 32'h2000_0000, 32'h7777_7777, 4'hf, 2, soc_pkg::DECERR, '0, 1'b0);
        add_row(OP_READ, 32'h2000_0000, '0, '0, 2, soc_pkg::DECERR, '0, 1'b1);
        add_row(OP_READ, DB, '0, '0, 0, soc_pkg::OKAY, d0, 1'b0);
    endtask

    task automatic write_txn(input row_t r);
        @(posedge aclk);
        awaddr  <= r.addr;
        wdata   <= r.data;
        wstrb   <= r.strb;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        @(negedge aclk);
        while (!(awready && wready)) @(negedge aclk);
        @(posedge aclk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(negedge aclk);
        while (!bvalid) @(negedge aclk);
        check_resp("bresp", r.exp_resp, bresp);
        // Response must hold while bready stays low
        repeat (r.delay) begin
            @(negedge aclk);
            if (!bvalid) begin
                stop_run("bvalid dropped while bready was held low");
            end
            check_resp("bresp", r.exp_resp, bresp);
        end
        @(posedge aclk);
        bready <= 1'b1;
        @(posedge aclk);
        bready <= 1'b0;
        if (r.exp_resp == soc_pkg::OKAY && r.addr == reg_addr(soc_pkg::REG_LED) && r.strb[0]) begin
            led_exp = r.data[soc_pkg::LED_W-1:0];
        end
        @(negedge aclk);
        check_led("led", led_exp, led);
    endtask

    task automatic read_txn(input row_t r);
        @(posedge aclk);
        araddr  <= r.addr;
        arvalid <= 1'b1;
        @(negedge aclk);
        check_fault("fault", r.exp_fault, fault);
        while (!arready) @(negedge aclk);
        @(posedge aclk);
        arvalid <= 1'b0;
        @(negedge aclk);
        check_fault("fault", 1'b0, fault);
        while (!rvalid) @(negedge aclk);
        check_resp("rresp", r.exp_resp, rresp);
        check_data("rdata", r.exp_data, rdata);
        repeat (r.delay) begin
            @(negedge aclk);
            if (!rvalid) begin
                stop_run("rvalid dropped while rready was held low");
            end
            check_resp("rresp", r.exp_resp, rresp);
            check_data("rdata", r.exp_data, rdata);
        end
        @(posedge aclk);
        rready <= 1'b1;
        @(posedge aclk);
        rready <= 1'b0;
    endtask

    task automatic fetch_txn(input row_t r);
        @(posedge aclk);
        fetch_addr <= r.addr;
        @(posedge aclk);
        @(negedge aclk);
        check_data("fetch_data", r.exp_data, fetch_data);
    endtask

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            stop_run("timeout: the tests did not finish within the cycle limit");
        end
    end

    initial begin
        arst_n     = 1'b0;
        awaddr     = '0;
        awprot     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arprot     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        fetch_addr = '0;
        build_table();
        limit = rows.size() * 20 + rows.size() * max_delay + 3;
        repeat (3) @(posedge aclk);
        arst_n <= 1'b1;
        @(negedge aclk);
        check_led("led", '0, led);
        foreach (rows[i]) begin
            case (rows[i].op)
                OP_WRITE: write_txn(rows[i]);
                OP_READ:  read_txn(rows[i]);
                default:  fetch_txn(rows[i]);
            endcase
        end
        $display("Done: no errors");
        $finish;
    end

endmodule : mem_system_tb

//--- filelist.f
design/soc_pkg.sv
design/axi_lite_if.sv
design/mem_router.sv
design/code_mem.sv
design/data_mem.sv
design/mmio_regs.sv
design/mem_system.sv
dv/mem_system_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module mem_system_tb -f filelist.f \
    -Mdir obj_dir -o mem_system_sim
./obj_dir/mem_system_sim
